// File: bench/robot_io_tb.sv
//////////////////////////////////////////////////////////////////////
// Robot I/O testbench
// SPI host, register table, PWM duty and LED dimming measurement
//////////////////////////////////////////////////////////////////////
`include "robot_io_defines.svh"

module robot_io_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF         = 8;                                // Clocks per SPI phase
    localparam int NUM_DRIVE    = `ROBOT_IO_NUM_DRIVE;
    localparam int DRIVE_PERIOD = 256 << `ROBOT_IO_DRIVE_TICK_LOG2;
    localparam int LED_PERIOD   = 256 << `ROBOT_IO_LED_TICK_LOG2;
    localparam int MEAS_PERIOD  = (DRIVE_PERIOD > LED_PERIOD) ? DRIVE_PERIOD : LED_PERIOD;
    localparam int SETTLE       = 16;                               // Past the ratio latch
    localparam int STIM_LEN     = 22;
    localparam int DUTY_ROUNDS  = 2;
    localparam int NUM_FRAMES   = STIM_LEN + DUTY_ROUNDS * 5 + 5;    // Table, rounds, abort
    localparam int FRAME_CYCLES = 16 * 2 * HALF + 3 * HALF + 8;
    localparam int MEAS_CYCLES  = 2 * MEAS_PERIOD + SETTLE;
    localparam int TIMEOUT_CYCLES =
        (NUM_FRAMES * FRAME_CYCLES + DUTY_ROUNDS * MEAS_CYCLES + 20) * 12 / 10;

    typedef enum logic {OP_READ, OP_WRITE} op_kind_e;

    // One table row
    typedef struct packed {
        op_kind_e            kind;
        spi_pkg::reg_addr_t  address;
        logic [7:0]          data;          // Write payload
        logic [7:0]          expected;      // Read result
    } stim_entry_t;

    logic       clock;
    logic       reset_n;
    logic       spi_clock;
    logic       cs_n;
    logic       mosi;
    logic       miso;
    logic [3:0] sd_pwm;
    logic [3:0] sd_dir;
    logic       status_fault;
    logic       status_pi;
    logic       status_ps4;
    logic       status_debug;

    stim_entry_t          stim [STIM_LEN];
    int                   stim_count;
    int                   error_count;
    int                   cycle_count;
    int                   drive_high [NUM_DRIVE];   // High clocks per drive channel
    int                   led_high [4];             // Fault, pi, ps4, debug
    logic [31:0]          rng_state;
    ctrl_pkg::drive_cmd_t last_drive;               // Latest round's drive bytes

    robot_io_top u_dut (
        .clock        (clock),
        .reset_n      (reset_n),
        .spi_clock    (spi_clock),
        .cs_n         (cs_n),
        .mosi         (mosi),
        .miso         (miso),
        .sd_pwm       (sd_pwm),
        .sd_dir       (sd_dir),
        .status_fault (status_fault),
        .status_pi    (status_pi),
        .status_ps4   (status_ps4),
        .status_debug (status_debug)
    );

    always #2 clock = ~clock;                       // 4 ns period

    // Run length guard
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_on_failure();
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checking
    //////////////////////////////////////////////////////////////////////
    task automatic stop_on_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_byte(input string name, input ctrl_pkg::reg_word_u got,
                              input ctrl_pkg::reg_word_u exp);
        if (got.raw !== exp.raw) begin
            error_count++;
            $display("[FAIL] %0t %s got 8'h%h expected 8'h%h", $time, name, got.raw, exp.raw);
            stop_on_failure();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            error_count++;
            $display("[FAIL] %0t %s high count got %0d expected %0d", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_bits(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %0t %s got 4'b%b expected 4'b%b", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    function automatic logic [31:0] next_random(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // SPI mode-0 host driven on falling clock edges
    //////////////////////////////////////////////////////////////////////
    task automatic shift_frame(input logic [15:0] bits, input int nbits, output logic [7:0] rx);
        rx = '0;
        @(negedge clock);
        cs_n = 1'b0;
        for (int i = 0; i < nbits; i++) begin
            mosi = bits[15-i];                          // MSB first
            repeat (HALF) @(negedge clock);
            if (i >= 8)
                rx = {rx[6:0], miso};                   // Stable since last fall
            spi_clock = 1'b1;
            repeat (HALF) @(negedge clock);
            spi_clock = 1'b0;
        end
        repeat (HALF) @(negedge clock);
        cs_n = 1'b1;                                    // Ends or aborts the frame
        mosi = 1'b0;
        repeat (HALF) @(negedge clock);                 // Register update settles
    endtask

    task automatic write_register(input spi_pkg::reg_addr_t addr, input logic [7:0] data);
        logic [7:0] unused;
        shift_frame({2'b10, addr, data}, 16, unused);
    endtask

    task automatic read_register(input spi_pkg::reg_addr_t addr, output logic [7:0] data);
        shift_frame({2'b00, addr, 8'h00}, 16, data);
    endtask

    task automatic add_entry(input op_kind_e kind, input int addr, input logic [7:0] data,
                             input logic [7:0] expected);
        stim[stim_count] = {kind, spi_pkg::reg_addr_t'(addr), data, expected};
        stim_count++;
    endtask

    // Counts high clocks over one full period of each PWM
    task automatic measure_outputs();
        for (int c = 0; c < NUM_DRIVE; c++)
            drive_high[c] = 0;
        for (int c = 0; c < 4; c++)
            led_high[c] = 0;
        for (int i = 0; i < MEAS_PERIOD; i++) begin
            @(negedge clock);
            for (int c = 0; c < NUM_DRIVE; c++)
                if (i < DRIVE_PERIOD && sd_pwm[c])
                    drive_high[c]++;
            if (i < LED_PERIOD) begin
                led_high[0] += status_fault;
                led_high[1] += status_pi;
                led_high[2] += status_ps4;
                led_high[3] += status_debug;
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Duty rounds and the aborted frame
    //////////////////////////////////////////////////////////////////////
    task automatic check_duty_round(input int round);
        ctrl_pkg::drive_cmd_t drv;
        ctrl_pkg::led_reg_t   led;
        logic [3:0]           dir_exp;
        int                   exp_cnt;
        int                   led_cnt;
        for (int ch = 0; ch < NUM_DRIVE; ch++) begin
            rng_state      = next_random(rng_state);
            drv[ch]        = rng_state[7:0];
            drv[ch].enable = (ch != round);             // One channel off per round
            dir_exp[ch]    = drv[ch].direction;
            write_register(spi_pkg::reg_addr_t'(ch), drv[ch]);
        end
        rng_state = next_random(rng_state);
        led       = rng_state[15:8];
        {led.fault, led.pi, led.ps4} = (round % 2) ? 3'b010 : 3'b101;  // Each flag on and off
        write_register(spi_pkg::reg_addr_t'(`ROBOT_IO_ADDR_LED), led);
        last_drive = drv;
        repeat (MEAS_PERIOD + SETTLE) @(negedge clock);   // Wrap latches new ratios
        measure_outputs();
        for (int ch = 0; ch < NUM_DRIVE; ch++) begin
            exp_cnt = drv[ch].enable ?
                int'(drv[ch].speed) * 4 * (1 << `ROBOT_IO_DRIVE_TICK_LOG2) : 0;
            check_count($sformatf("sd_pwm[%0d]", ch), drive_high[ch], exp_cnt);
        end
        check_bits("sd_dir", sd_dir, dir_exp);
        led_cnt = int'(led.brightness) * 16 * (1 << `ROBOT_IO_LED_TICK_LOG2);
        check_count("status_fault", led_high[0], led.fault ? led_cnt : 0);
        check_count("status_pi", led_high[1], led.pi ? led_cnt : 0);
        check_count("status_ps4", led_high[2], led.ps4 ? led_cnt : 0);
        check_count("status_debug", led_high[3], led_cnt);
    endtask

    task automatic check_abort_frame();
        logic [7:0] rd;
        logic [7:0] unused;
        read_register(6'd2, rd);
        check_byte("rd_data addr 2 before abort", rd, last_drive[2]);
        shift_frame({2'b10, 6'd2, 8'h5A}, 10, unused);  // Ten bits then deselect
        read_register(6'd2, rd);
        check_byte("rd_data addr 2 after abort", rd, last_drive[2]);
        write_register(6'd2, 8'h5A);
        read_register(6'd2, rd);
        check_byte("rd_data addr 2 after full frame", rd, 8'h5A);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        logic [7:0] rd;
        clock       = 1'b0;
        reset_n     = 1'b0;
        spi_clock   = 1'b0;
        cs_n        = 1'b1;
        mosi        = 1'b0;
        stim_count  = 0;
        error_count = 0;
        cycle_count = 0;
        rng_state   = 32'habfd75ab;

        for (int a = 0; a < 5; a++)                     // Reset values
            add_entry(OP_READ, a, 8'h00, 8'h00);
        add_entry(OP_READ, `ROBOT_IO_ADDR_ID, 8'h00, `ROBOT_IO_ID);
        add_entry(OP_READ, 9, 8'h00, 8'h00);
        add_entry(OP_WRITE, 0, 8'h9F, 8'h00);
        add_entry(OP_READ, 0, 8'h00, 8'h9F);
        add_entry(OP_WRITE, 1, 8'h45, 8'h00);
        add_entry(OP_READ, 1, 8'h00, 8'h45);
        add_entry(OP_WRITE, 2, 8'hE3, 8'h00);
        add_entry(OP_READ, 2, 8'h00, 8'hE3);
        add_entry(OP_WRITE, 3, 8'h20, 8'h00);
        add_entry(OP_READ, 3, 8'h00, 8'h20);
        add_entry(OP_WRITE, `ROBOT_IO_ADDR_LED, 8'hF6, 8'h00);
        add_entry(OP_READ, `ROBOT_IO_ADDR_LED, 8'h00, 8'hF6);
        add_entry(OP_WRITE, `ROBOT_IO_ADDR_ID, 8'h3C, 8'h00);  // Read-only
        add_entry(OP_READ, `ROBOT_IO_ADDR_ID, 8'h00, `ROBOT_IO_ID);
        add_entry(OP_WRITE, 9, 8'h77, 8'h00);                  // Unmapped
        add_entry(OP_READ, 9, 8'h00, 8'h00);
        add_entry(OP_READ, 1, 8'h00, 8'h45);                   // No alias of address 9

        repeat (5) @(negedge clock);
        reset_n = 1'b1;
        @(negedge clock);
        check_bits("sd_pwm", sd_pwm, 4'h0);
        check_bits("sd_dir", sd_dir, 4'h0);
        check_bits("status", {status_fault, status_pi, status_ps4, status_debug}, 4'h0);
        check_bits("miso", {3'b000, miso}, 4'h0);

        for (int i = 0; i < STIM_LEN; i++) begin
            if (stim[i].kind == OP_WRITE) begin
                write_register(stim[i].address, stim[i].data);
            end else begin
                read_register(stim[i].address, rd);
                check_byte($sformatf("rd_data addr %0d", stim[i].address), rd,
                           stim[i].expected);
            end
        end

        for (int r = 0; r < DUTY_ROUNDS; r++)
            check_duty_round(r);
        check_abort_frame();

        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            stop_on_failure();
        end
    end

endmodule

// File: source/actuator_outputs.sv
//////////////////////////////////////////////////////////////////////
// Actuator outputs
// Tick divider, drive motor PWM and direction, dimmed status LEDs
//////////////////////////////////////////////////////////////////////
`include "robot_io_defines.svh"

module actuator_outputs (
    input  logic                 clock,         // System clock
    input  logic                 reset_n,       // Async reset, active low
    input  ctrl_pkg::drive_cmd_t drive_cmd,     // Drive channel controls
    input  ctrl_pkg::led_reg_t   led_cmd,       // LED control
    output logic [3:0]           sd_pwm,        // Drive PWM waves
    output logic [3:0]           sd_dir,        // Drive direction pins
    output logic                 status_fault,
    output logic                 status_pi,
    output logic                 status_ps4,
    output logic                 status_debug   // Raw LED wave
);

    localparam int DRIVE_TAP = `ROBOT_IO_DRIVE_TICK_LOG2;
    localparam int LED_TAP   = `ROBOT_IO_LED_TICK_LOG2;
    localparam int DIV_W     = (DRIVE_TAP > LED_TAP ? DRIVE_TAP : LED_TAP) + 1;
    localparam logic [DIV_W-1:0] DRIVE_MASK = (DIV_W'(1) << DRIVE_TAP) - 1'b1;
    localparam logic [DIV_W-1:0] LED_MASK   = (DIV_W'(1) << LED_TAP) - 1'b1;

    logic [DIV_W-1:0] div_cnt;      // Free-running divider
    logic             drive_tick;
    logic             led_tick;
    logic             led_wave;

    //////////////////////////////////////////////////////////////////////
    // Tick divider
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 1'b1;
    end

    assign drive_tick = (div_cnt & DRIVE_MASK) == DRIVE_MASK;  // Every 2^tap
    assign led_tick   = (div_cnt & LED_MASK) == LED_MASK;

    //////////////////////////////////////////////////////////////////////
    // Drive channels
    //////////////////////////////////////////////////////////////////////
    for (genvar i = 0; i < `ROBOT_IO_NUM_DRIVE; i++) begin : g_drive
        pwm_channel #(.TICK_LOG2(DRIVE_TAP)) u_pwm (
            .clock      (clock),
            .reset_n    (reset_n),
            .tick       (drive_tick),
            .enable     (drive_cmd[i].enable),
            .ratio      ({1'b0, drive_cmd[i].speed, 2'b00}),   // Speed x 4
            .pwm_signal (sd_pwm[i])
        );
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n)
            sd_dir <= '0;
        else
            for (int i = 0; i < `ROBOT_IO_NUM_DRIVE; i++)
                sd_dir[i] <= drive_cmd[i].direction;
    end

    //////////////////////////////////////////////////////////////////////
    // Status LEDs
    //////////////////////////////////////////////////////////////////////
    pwm_channel #(.TICK_LOG2(LED_TAP)) u_led (
        .clock      (clock),
        .reset_n    (reset_n),
        .tick       (led_tick),
        .enable     (1'b1),                             // Always dimming
        .ratio      ({led_cmd.brightness, 4'b0000}),    // Brightness x 16
        .pwm_signal (led_wave)
    );

    assign status_fault = led_wave & led_cmd.fault;
    assign status_pi    = led_wave & led_cmd.pi;
    assign status_ps4   = led_wave & led_cmd.ps4;
    assign status_debug = led_wave;

endmodule

// File: source/control_regs.sv
//////////////////////////////////////////////////////////////////////
// Control register file
// Drive and LED registers, ID readback, actuator command levels
//////////////////////////////////////////////////////////////////////
`include "robot_io_defines.svh"

module control_regs (
    input  logic                        clock,      // System clock
    input  logic                        reset_n,    // Async reset, active low
    input  spi_pkg::reg_access_t        access,     // Access from SPI target
    output logic [`ROBOT_IO_DATA_W-1:0] rd_data,    // Read data, same cycle
    output ctrl_pkg::drive_cmd_t        drive_cmd,  // Drive channel controls
    output ctrl_pkg::led_reg_t          led_cmd     // LED control
);

    localparam int NUM_REGS = `ROBOT_IO_ADDR_LED + 1;   // Drives then LED

    ctrl_pkg::reg_word_u regs [NUM_REGS];

    //////////////////////////////////////////////////////////////////////
    // Write decode
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end else if (access.write_en) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                if (access.address == i)
                    regs[i].raw <= access.wr_data;  // ID and holes fall through
            end
        end
    end

    // Read mux
    always_comb begin
        rd_data = '0;                               // Unmapped reads
        if (access.address == `ROBOT_IO_ADDR_ID)
            rd_data = `ROBOT_IO_ID;
        for (int i = 0; i < NUM_REGS; i++) begin
            if (access.address == i)
                rd_data = regs[i].raw;
        end
    end

    // Same storage decoded per address
    always_comb begin
        for (int i = 0; i < `ROBOT_IO_NUM_DRIVE; i++)
            drive_cmd[i] = regs[i].drive;
        led_cmd = regs[`ROBOT_IO_ADDR_LED].led;
    end

    // Decode of an X address would corrupt a register silently
    a_addr_known: assert property (@(posedge clock) disable iff (!reset_n)
        (access.write_en || access.read_en) |-> !$isunknown(access.address));

endmodule

// File: source/ctrl_pkg.sv
//////////////////////////////////////////////////////////////////////
// Control register types
// Register layouts and the actuator command bundles
//////////////////////////////////////////////////////////////////////
`include "robot_io_defines.svh"

package ctrl_pkg;

    // Drive channel control byte
    typedef struct packed {
        logic       enable;         // Channel on
        logic       direction;      // Motor direction pin
        logic       reserved;       // Unused
        logic [4:0] speed;          // Duty in steps of 4/256
    } drive_reg_t;

    // Status LED control byte
    typedef struct packed {
        logic [3:0] brightness;     // Duty in steps of 16/256
        logic       fault;          // Fault LED on
        logic       pi;             // Host link LED on
        logic       ps4;            // Controller LED on
        logic       spare;          // Unused
    } led_reg_t;

    // One stored byte, viewed by its address
    typedef union packed {
        drive_reg_t                  drive;   // Addresses 0..3
        led_reg_t                    led;     // LED address
        logic [`ROBOT_IO_DATA_W-1:0] raw;     // Bus view
    } reg_word_u;

    typedef drive_reg_t [`ROBOT_IO_NUM_DRIVE-1:0] drive_cmd_t;  // All drive channels

endpackage

// File: source/pwm_channel.sv
//////////////////////////////////////////////////////////////////////
// Tick-paced 8-bit PWM generator
// Ratio and enable take effect at the period wrap
//////////////////////////////////////////////////////////////////////
`include "robot_io_defines.svh"

module pwm_channel #(
    parameter int TICK_LOG2 = 0                     // Divider tap feeding tick
) (
    input  logic       clock,       // System clock
    input  logic       reset_n,     // Async reset, active low
    input  logic       tick,        // Advance strobe
    input  logic       enable,      // Channel on
    input  logic [7:0] ratio,       // High ticks per 256
    output logic       pwm_signal   // PWM wave
);

    logic [7:0] tick_cnt;           // Position in period
    logic [7:0] ratio_q;            // Latched at wrap
    logic       enable_q;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            tick_cnt   <= '0;
            ratio_q    <= '0;
            enable_q   <= 1'b0;
            pwm_signal <= 1'b0;
        end else begin
            if (tick) begin
                tick_cnt <= tick_cnt + 8'd1;
                if (tick_cnt == 8'hFF) begin    // Period boundary
                    ratio_q  <= ratio;
                    enable_q <= enable;
                end
            end
            pwm_signal <= enable_q && (tick_cnt < ratio_q);
        end
    end

    // Divider and channel agree on the tick spacing
    a_tick_spacing: assert property (@(posedge clock) disable iff (!reset_n)
        tick |-> ##(1 << TICK_LOG2) tick);

    // A disabled period produces no pulse
    a_off_low: assert property (@(posedge clock) disable iff (!reset_n)
        !enable_q |-> !pwm_signal);

endmodule

// File: source/robot_io_defines.svh
//////////////////////////////////////////////////////////////////////
// Robot I/O shared constants
// Widths, register map, PWM divider taps and the identification value
//////////////////////////////////////////////////////////////////////
`ifndef ROBOT_IO_DEFINES_SVH
`define ROBOT_IO_DEFINES_SVH

`define ROBOT_IO_ADDR_W          6      // Register address bits
`define ROBOT_IO_DATA_W          8      // Register data bits
`define ROBOT_IO_NUM_DRIVE       4      // Drive channels at addresses 0..3

`define ROBOT_IO_ADDR_LED        4      // Status LED control
`define ROBOT_IO_ADDR_ID         5      // Read-only identification
`define ROBOT_IO_ID              8'hA5

// Divider taps shortened for simulation
`define ROBOT_IO_DRIVE_TICK_LOG2 3
`define ROBOT_IO_LED_TICK_LOG2   4

`define ROBOT_IO_SYNC_STAGES     2      // SPI pin synchronizer depth

`endif

// File: source/robot_io_top.sv
//////////////////////////////////////////////////////////////////////
// Robot I/O top level
// SPI target, control registers and actuator outputs
//////////////////////////////////////////////////////////////////////
`include "robot_io_defines.svh"

module robot_io_top (
    input  logic       clock,           // System clock
    input  logic       reset_n,         // Async reset, active low
    input  logic       spi_clock,       // SPI clock
    input  logic       cs_n,            // SPI chip select
    input  logic       mosi,            // SPI data in
    output logic       miso,            // SPI data out
    output logic [3:0] sd_pwm,          // Drive PWM
    output logic [3:0] sd_dir,          // Drive direction
    output logic       status_fault,    // Fault LED
    output logic       status_pi,       // Host link LED
    output logic       status_ps4,      // Controller LED
    output logic       status_debug     // Debug LED
);

    spi_pkg::reg_access_t        access;
    logic [`ROBOT_IO_DATA_W-1:0] rd_data;
    ctrl_pkg::drive_cmd_t        drive_cmd;
    ctrl_pkg::led_reg_t          led_cmd;

    spi_target u_spi (
        .clock     (clock),
        .reset_n   (reset_n),
        .spi_clock (spi_clock),
        .cs_n      (cs_n),
        .mosi      (mosi),
        .rd_data   (rd_data),
        .miso      (miso),
        .access    (access)
    );

    control_regs u_regs (
        .clock     (clock),
        .reset_n   (reset_n),
        .access    (access),
        .rd_data   (rd_data),
        .drive_cmd (drive_cmd),
        .led_cmd   (led_cmd)
    );

    actuator_outputs u_outputs (
        .clock        (clock),
        .reset_n      (reset_n),
        .drive_cmd    (drive_cmd),
        .led_cmd      (led_cmd),
        .sd_pwm       (sd_pwm),
        .sd_dir       (sd_dir),
        .status_fault (status_fault),
        .status_pi    (status_pi),
        .status_ps4   (status_ps4),
        .status_debug (status_debug)
    );

endmodule

// File: source/spi_pkg.sv
//////////////////////////////////////////////////////////////////////
// SPI access types
// Register address and the access strobe bundle from the SPI target
//////////////////////////////////////////////////////////////////////
`include "robot_io_defines.svh"

package spi_pkg;

    typedef logic [`ROBOT_IO_ADDR_W-1:0] reg_addr_t;    // Register address

    // One register access with single-clock strobes
    typedef struct packed {
        reg_addr_t                   address;           // Target register
        logic                        write_en;          // Write strobe
        logic                        read_en;           // Read strobe
        logic [`ROBOT_IO_DATA_W-1:0] wr_data;           // Write payload
    } reg_access_t;

endpackage

// File: source/spi_target.sv
//////////////////////////////////////////////////////////////////////
// SPI mode-0 target
// Oversamples the SPI pins, decodes 16-bit frames into register accesses
//////////////////////////////////////////////////////////////////////
`include "robot_io_defines.svh"

module spi_target (
    input  logic                        clock,      // System clock
    input  logic                        reset_n,    // Async reset, active low
    input  logic                        spi_clock,  // SPI clock from host
    input  logic                        cs_n,       // Chip select, active low
    input  logic                        mosi,       // Host to target data
    input  logic [`ROBOT_IO_DATA_W-1:0] rd_data,    // Register read data
    output logic                        miso,       // Target to host data
    output spi_pkg::reg_access_t        access      // Register access
);

    localparam int STAGES = `ROBOT_IO_SYNC_STAGES;
    localparam int DW     = `ROBOT_IO_DATA_W;

    logic [STAGES-1:0] sclk_sync;       // SPI clock synchronizer
    logic [STAGES-1:0] cs_sync;         // Chip select synchronizer
    logic [STAGES-1:0] mosi_sync;       // Data synchronizer
    logic              sclk_prev;       // For edge detection
    logic              sclk_rise;
    logic              sclk_fall;
    logic              cs_s;
    logic              mosi_s;
    logic [4:0]        bit_cnt;         // Rising edges this frame
    logic [DW-1:0]     rx_shift;        // Incoming bits
    logic [DW-1:0]     tx_shift;        // Outgoing read data
    logic              is_write;        // Command bit of byte 0
    logic              miso_q;

    //////////////////////////////////////////////////////////////////////
    // Pin synchronizers and edge detect
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            sclk_sync <= '0;
            cs_sync   <= '1;                // Deselected
            mosi_sync <= '0;
            sclk_prev <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[STAGES-2:0], spi_clock};
            cs_sync   <= {cs_sync[STAGES-2:0], cs_n};
            mosi_sync <= {mosi_sync[STAGES-2:0], mosi};
            sclk_prev <= sclk_sync[STAGES-1];
        end
    end

    assign cs_s      = cs_sync[STAGES-1];
    assign mosi_s    = mosi_sync[STAGES-1];
    assign sclk_rise = sclk_sync[STAGES-1] & ~sclk_prev;   // Sample point
    assign sclk_fall = ~sclk_sync[STAGES-1] & sclk_prev;   // Shift-out point

    //////////////////////////////////////////////////////////////////////
    // Frame decode
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            bit_cnt  <= '0;
            rx_shift <= '0;
            tx_shift <= '0;
            is_write <= 1'b0;
            miso_q   <= 1'b0;
            access   <= '0;
        end else begin
            access.read_en  <= 1'b0;        // Strobes are single pulses
            access.write_en <= 1'b0;
            if (cs_s) begin                 // Idle or aborted frame
                bit_cnt  <= '0;
                tx_shift <= '0;
                miso_q   <= 1'b0;
            end else begin
                if (access.read_en)
                    tx_shift <= rd_data;    // Capture alongside the strobe
                if (sclk_rise) begin
                    rx_shift <= {rx_shift[DW-2:0], mosi_s};
                    bit_cnt  <= bit_cnt + 5'd1;
                    if (bit_cnt == 5'd7) begin      // Byte 0 complete
                        access.address <= {rx_shift[4:0], mosi_s};
                        is_write       <= rx_shift[6];
                        access.read_en <= ~rx_shift[6];
                    end
                    if (bit_cnt == 5'd15 && is_write) begin
                        access.wr_data  <= {rx_shift[DW-2:0], mosi_s};
                        access.write_en <= 1'b1;
                    end
                end
                if (sclk_fall) begin        // Zeros until read data loads
                    miso_q   <= tx_shift[DW-1];
                    tx_shift <= {tx_shift[DW-2:0], 1'b0};
                end
            end
        end
    end

    assign miso = miso_q & ~cs_n;           // Quiet when deselected

    // Read and write come from different bytes of one frame
    a_one_strobe: assert property (@(posedge clock) disable iff (!reset_n)
        !(access.read_en && access.write_en));

endmodule

// File: vlog.f
+incdir+source
source/spi_pkg.sv
source/ctrl_pkg.sv
source/spi_target.sv
source/control_regs.sv
source/pwm_channel.sv
source/actuator_outputs.sv
source/robot_io_top.sv
bench/robot_io_tb.sv
